// File: Makefile
VERILATOR ?= verilator
FLIST     ?= verilog.f
TOP       ?= id_stage_tb
RTL_TOP   ?= id_stage
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: design/id_stage.sv
// Decode stage top: decoder, operand muxes, register file and wait FSM.
// EX and LSU requests are combinational from the current instruction.

`timescale 1ns/1ps

module id_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      instr_new_i,
  input  idd_pkg::instr_t           instr_i,
  input  logic [idd_pkg::XLEN-1:0]  pc_i,
  input  logic                      branch_decision_i,
  input  logic                      ex_valid_i,
  input  logic [idd_pkg::XLEN-1:0]  ex_wdata_i,
  input  logic                      lsu_valid_i,
  input  logic [idd_pkg::XLEN-1:0]  lsu_rdata_i,
  output idd_pkg::ex_req_t          ex_req_o,
  output idd_pkg::lsu_req_t         lsu_req_o,
  output logic                      branch_set_o,
  output logic                      id_ready_o,
  output logic                      instr_ret_o,
  output logic                      illegal_insn_o
);

  idd_pkg::dec_ctrl_t       ctrl;
  logic [idd_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [idd_pkg::XLEN-1:0] rdata_a, rdata_b;
  logic [idd_pkg::XLEN-1:0] operand_a, operand_b;
  logic [idd_pkg::XLEN-1:0] rf_wdata;
  logic                     rf_we;
  logic                     lsu_req_valid;

  instr_decoder u_decoder (
    .instr_i (instr_i),
    .ctrl_o  (ctrl),
    .imm_i_o (imm_i),
    .imm_s_o (imm_s),
    .imm_b_o (imm_b),
    .imm_u_o (imm_u),
    .imm_j_o (imm_j)
  );

  operand_mux u_operand_mux (
    .ctrl_i      (ctrl),
    .imm_i_i     (imm_i),
    .imm_s_i     (imm_s),
    .imm_b_i     (imm_b),
    .imm_u_i     (imm_u),
    .imm_j_i     (imm_j),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .pc_i        (pc_i),
    .operand_a_o (operand_a),
    .operand_b_o (operand_b)
  );

  register_file u_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (ctrl.rs1),
    .raddr_b_i (ctrl.rs2),
    .waddr_i   (ctrl.rd),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  multicycle_fsm u_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_new_i       (instr_new_i),
    .ctrl_i            (ctrl),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (ex_valid_i),
    .lsu_valid_i       (lsu_valid_i),
    .ex_wdata_i        (ex_wdata_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .rf_we_o           (rf_we),
    .rf_wdata_o        (rf_wdata),
    .lsu_req_valid_o   (lsu_req_valid),
    .branch_set_o      (branch_set_o),
    .id_ready_o        (id_ready_o),
    .instr_ret_o       (instr_ret_o),
    .illegal_insn_o    (illegal_insn_o)
  );

  // Requests to EX and LSU
  assign ex_req_o.alu_op    = ctrl.alu_op;
  assign ex_req_o.operand_a = operand_a;
  assign ex_req_o.operand_b = operand_b;

  assign lsu_req_o.req      = lsu_req_valid;
  assign lsu_req_o.we       = ctrl.mem_we;
  assign lsu_req_o.mem_type = ctrl.mem_type;
  assign lsu_req_o.sign_ext = ctrl.mem_sign_ext;
  // Store data always comes from rs2
  assign lsu_req_o.wdata    = rdata_b;

endmodule

// File: design/idd_pkg.sv
// Shared widths, encodings and bundles for the RV32I decode stage.
// Only the base integer subset used by this stage is encoded here.

package idd_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    // Comparisons for branches
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J,
    IMM_B_INCR_PC  // Constant 4 for the link value
  } imm_b_sel_e;

  typedef enum logic {RF_WD_EX, RF_WD_LSU} rf_wd_sel_e;
  typedef enum logic [1:0] {MEM_WORD, MEM_HALF, MEM_BYTE} mem_type_e;

  ////////////////////////////////////////////////////////////
  // Instruction word, two views of the same bits
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    opcode_e               opcode;
  } instr_r_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    opcode_e               opcode;
  } instr_s_t;

  typedef union packed {
    instr_r_t r;
    instr_s_t s;
  } instr_t;

  ////////////////////////////////////////////////////////////
  // Decoder output and requests
  ////////////////////////////////////////////////////////////

  // Exactly one flag set per instruction
  typedef struct packed {
    logic is_load_store;
    logic is_branch;
    logic is_jump;
    logic is_alu;
  } instr_class_t;

  typedef struct packed {
    instr_class_t          iclass;
    logic                  illegal;
    logic                  rf_we;
    rf_wd_sel_e            rf_wd_sel;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_e               alu_op;
    op_a_sel_e             op_a_sel;
    op_b_sel_e             op_b_sel;
    imm_b_sel_e            imm_b_sel;
    logic                  mem_we;
    mem_type_e             mem_type;
    logic                  mem_sign_ext;
  } dec_ctrl_t;

  typedef struct packed {
    alu_op_e         alu_op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } ex_req_t;

  typedef struct packed {
    logic            req;
    logic            we;
    mem_type_e       mem_type;
    logic            sign_ext;
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

endpackage

// File: design/instr_decoder.sv
// RV32I subset decoder: OP-IMM, OP, LUI, AUIPC, JAL, BRANCH, LOAD, STORE.
// Anything else is flagged illegal and decoded as a harmless ALU op
// with no register or memory write.

`timescale 1ns/1ps

module instr_decoder (
  input  idd_pkg::instr_t           instr_i,
  output idd_pkg::dec_ctrl_t        ctrl_o,
  output logic [idd_pkg::XLEN-1:0]  imm_i_o,
  output logic [idd_pkg::XLEN-1:0]  imm_s_o,
  output logic [idd_pkg::XLEN-1:0]  imm_b_o,
  output logic [idd_pkg::XLEN-1:0]  imm_u_o,
  output logic [idd_pkg::XLEN-1:0]  imm_j_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       sign;

  assign funct3 = instr_i.r.funct3;
  assign funct7 = instr_i.r.funct7;
  assign sign   = instr_i.r.funct7[6];

  ////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////

  assign imm_i_o = {{20{sign}}, instr_i.r.funct7, instr_i.r.rs2};
  assign imm_s_o = {{20{sign}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
  assign imm_b_o = {{19{sign}}, instr_i.s.imm_hi[6], instr_i.s.imm_lo[0],
                    instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};
  assign imm_u_o = {instr_i.r.funct7, instr_i.r.rs2, instr_i.r.rs1, funct3, 12'h000};
  // J-type bits are scattered over rs1, funct3, rs2 and funct7
  assign imm_j_o = {{12{sign}}, instr_i.r.rs1, funct3, instr_i.r.rs2[0],
                    funct7[5:0], instr_i.r.rs2[4:1], 1'b0};

  ////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////

  always_comb begin : decode
    ctrl_o               = '0;
    ctrl_o.rs1           = instr_i.r.rs1;
    ctrl_o.rs2           = instr_i.r.rs2;
    ctrl_o.rd            = instr_i.r.rd;
    ctrl_o.alu_op        = idd_pkg::ALU_ADD;
    ctrl_o.op_a_sel      = idd_pkg::OP_A_REG_A;
    ctrl_o.op_b_sel      = idd_pkg::OP_B_IMM;
    ctrl_o.imm_b_sel     = idd_pkg::IMM_B_I;
    ctrl_o.rf_wd_sel     = idd_pkg::RF_WD_EX;
    ctrl_o.mem_type      = idd_pkg::MEM_WORD;

    case (instr_i.r.opcode)
      idd_pkg::OPCODE_OP_IMM, idd_pkg::OPCODE_OP: begin
        ctrl_o.rf_we = 1'b1;
        if (instr_i.r.opcode == idd_pkg::OPCODE_OP) begin
          ctrl_o.op_b_sel = idd_pkg::OP_B_REG_B;
        end
        case (funct3)
          3'b000: ctrl_o.alu_op = idd_pkg::ALU_ADD;
          3'b001: ctrl_o.alu_op = idd_pkg::ALU_SLL;
          3'b010: ctrl_o.alu_op = idd_pkg::ALU_SLT;
          3'b011: ctrl_o.alu_op = idd_pkg::ALU_SLTU;
          3'b100: ctrl_o.alu_op = idd_pkg::ALU_XOR;
          3'b101: ctrl_o.alu_op = funct7[5] ? idd_pkg::ALU_SRA : idd_pkg::ALU_SRL;
          3'b110: ctrl_o.alu_op = idd_pkg::ALU_OR;
          default: ctrl_o.alu_op = idd_pkg::ALU_AND;
        endcase
        // SUB only exists in OP; immediates of OP-IMM shifts carry funct7
        if (instr_i.r.opcode == idd_pkg::OPCODE_OP && funct3 == 3'b000 && funct7[5]) begin
          ctrl_o.alu_op = idd_pkg::ALU_SUB;
        end
        if (instr_i.r.opcode == idd_pkg::OPCODE_OP || funct3 inside {3'b001, 3'b101}) begin
          ctrl_o.illegal = (funct7 != 7'h00) &&
                           !(funct7 == 7'h20 && funct3 inside {3'b000, 3'b101});
          if (instr_i.r.opcode == idd_pkg::OPCODE_OP_IMM && funct3 == 3'b001) begin
            ctrl_o.illegal = (funct7 != 7'h00);
          end
        end
      end
      idd_pkg::OPCODE_LUI, idd_pkg::OPCODE_AUIPC: begin
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.imm_b_sel = idd_pkg::IMM_B_U;
        ctrl_o.op_a_sel  = (instr_i.r.opcode == idd_pkg::OPCODE_LUI) ?
                           idd_pkg::OP_A_ZERO : idd_pkg::OP_A_CURRPC;
      end
      idd_pkg::OPCODE_JAL: begin
        // EX computes the link value PC + 4
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_a_sel  = idd_pkg::OP_A_CURRPC;
        ctrl_o.imm_b_sel = idd_pkg::IMM_B_INCR_PC;
      end
      idd_pkg::OPCODE_BRANCH: begin
        ctrl_o.op_b_sel  = idd_pkg::OP_B_REG_B;
        ctrl_o.imm_b_sel = idd_pkg::IMM_B_B;
        case (funct3)
          3'b000: ctrl_o.alu_op = idd_pkg::ALU_EQ;
          3'b001: ctrl_o.alu_op = idd_pkg::ALU_NE;
          3'b100: ctrl_o.alu_op = idd_pkg::ALU_LT;
          3'b101: ctrl_o.alu_op = idd_pkg::ALU_GE;
          3'b110: ctrl_o.alu_op = idd_pkg::ALU_LTU;
          3'b111: ctrl_o.alu_op = idd_pkg::ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      idd_pkg::OPCODE_LOAD, idd_pkg::OPCODE_STORE: begin
        // Address is rs1 + immediate
        case (funct3[1:0])
          2'b00:   ctrl_o.mem_type = idd_pkg::MEM_BYTE;
          2'b01:   ctrl_o.mem_type = idd_pkg::MEM_HALF;
          default: ctrl_o.mem_type = idd_pkg::MEM_WORD;
        endcase
        if (instr_i.r.opcode == idd_pkg::OPCODE_LOAD) begin
          ctrl_o.rf_we        = 1'b1;
          ctrl_o.rf_wd_sel    = idd_pkg::RF_WD_LSU;
          ctrl_o.mem_sign_ext = ~funct3[2];
          ctrl_o.illegal      = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
        end else begin
          ctrl_o.mem_we    = 1'b1;
          ctrl_o.imm_b_sel = idd_pkg::IMM_B_S;
          ctrl_o.illegal   = (funct3[2] || funct3[1:0] == 2'b11);
        end
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal words must not write or start a multicycle sequence
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we  = 1'b0;
      ctrl_o.mem_we = 1'b0;
    end

    // Illegal words fall into the ALU class
    ctrl_o.iclass.is_load_store = !ctrl_o.illegal &&
      (instr_i.r.opcode inside {idd_pkg::OPCODE_LOAD, idd_pkg::OPCODE_STORE});
    ctrl_o.iclass.is_branch = !ctrl_o.illegal &&
      (instr_i.r.opcode == idd_pkg::OPCODE_BRANCH);
    ctrl_o.iclass.is_jump = !ctrl_o.illegal &&
      (instr_i.r.opcode == idd_pkg::OPCODE_JAL);
    ctrl_o.iclass.is_alu = ctrl_o.illegal ||
      (instr_i.r.opcode inside {idd_pkg::OPCODE_OP_IMM, idd_pkg::OPCODE_OP,
                                idd_pkg::OPCODE_LUI, idd_pkg::OPCODE_AUIPC});

    assert ($onehot(ctrl_o.iclass))
      else $error("instruction class flags not one-hot");
  end

endmodule

// File: design/multicycle_fsm.sv
// Issue and write-back sequencing for the decode stage.
// Loads, stores, jumps and taken branches wait for their completion strobe;
// fetch must hold the instruction stable while id_ready_o is low.

`timescale 1ns/1ps

module multicycle_fsm (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            instr_new_i,
  input  idd_pkg::dec_ctrl_t              ctrl_i,
  input  logic                            branch_decision_i,
  input  logic                            ex_valid_i,
  input  logic                            lsu_valid_i,
  input  logic [idd_pkg::XLEN-1:0]        ex_wdata_i,
  input  logic [idd_pkg::XLEN-1:0]        lsu_rdata_i,
  output logic                            rf_we_o,
  output logic [idd_pkg::XLEN-1:0]        rf_wdata_o,
  output logic                            lsu_req_valid_o,
  output logic                            branch_set_o,
  output logic                            id_ready_o,
  output logic                            instr_ret_o,
  output logic                            illegal_insn_o
);

  typedef enum logic {IDLE, WAIT_MULTICYCLE} state_e;

  state_e state_q, state_d;
  logic   branch_set_d;
  logic   done;

  // Loads and stores complete from the LSU, jumps and branches from EX
  assign done = ctrl_i.iclass.is_load_store ? lsu_valid_i : ex_valid_i;

  always_comb begin : fsm
    state_d         = state_q;
    branch_set_d    = 1'b0;
    rf_we_o         = 1'b0;
    lsu_req_valid_o = 1'b0;
    instr_ret_o     = 1'b0;

    case (state_q)
      IDLE: begin
        if (instr_new_i && !ctrl_i.illegal) begin
          if (ctrl_i.iclass.is_load_store) begin
            lsu_req_valid_o = 1'b1;
            state_d         = WAIT_MULTICYCLE;
          end else if (ctrl_i.iclass.is_jump) begin
            state_d = WAIT_MULTICYCLE;
          end else if (ctrl_i.iclass.is_branch) begin
            // Not-taken branch is done now
            state_d      = branch_decision_i ? WAIT_MULTICYCLE : IDLE;
            branch_set_d = branch_decision_i;
            instr_ret_o  = ~branch_decision_i;
          end else begin
            rf_we_o     = ctrl_i.rf_we;
            instr_ret_o = 1'b1;
          end
        end
      end
      default: begin
        lsu_req_valid_o = ctrl_i.iclass.is_load_store;
        if (done) begin
          state_d     = IDLE;
          rf_we_o     = ctrl_i.rf_we;
          instr_ret_o = 1'b1;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      branch_set_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      branch_set_o <= branch_set_d;
    end
  end

  assign rf_wdata_o     = (ctrl_i.rf_wd_sel == idd_pkg::RF_WD_LSU) ? lsu_rdata_i : ex_wdata_i;
  assign id_ready_o     = (state_q == IDLE);
  assign illegal_insn_o = instr_new_i & ctrl_i.illegal & (state_q == IDLE);

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni) !$isunknown(state_q))
    else $error("decode FSM state unknown");

  // Fetch must respect id_ready_o
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (state_q == WAIT_MULTICYCLE) |-> !instr_new_i)
    else $error("new instruction while waiting on multicycle completion");

endmodule

// File: design/operand_mux.sv
// ALU operand selection for the decode stage.
// Operand B immediate also covers the constant 4 for jump link values.

`timescale 1ns/1ps

module operand_mux (
  input  idd_pkg::dec_ctrl_t        ctrl_i,
  input  logic [idd_pkg::XLEN-1:0]  imm_i_i,
  input  logic [idd_pkg::XLEN-1:0]  imm_s_i,
  input  logic [idd_pkg::XLEN-1:0]  imm_b_i,
  input  logic [idd_pkg::XLEN-1:0]  imm_u_i,
  input  logic [idd_pkg::XLEN-1:0]  imm_j_i,
  input  logic [idd_pkg::XLEN-1:0]  rdata_a_i,
  input  logic [idd_pkg::XLEN-1:0]  rdata_b_i,
  input  logic [idd_pkg::XLEN-1:0]  pc_i,
  output logic [idd_pkg::XLEN-1:0]  operand_a_o,
  output logic [idd_pkg::XLEN-1:0]  operand_b_o
);

  logic [idd_pkg::XLEN-1:0] imm_b;

  always_comb begin : imm_b_mux
    case (ctrl_i.imm_b_sel)
      idd_pkg::IMM_B_I: imm_b = imm_i_i;
      idd_pkg::IMM_B_S: imm_b = imm_s_i;
      idd_pkg::IMM_B_B: imm_b = imm_b_i;
      idd_pkg::IMM_B_U: imm_b = imm_u_i;
      idd_pkg::IMM_B_J: imm_b = imm_j_i;
      default:          imm_b = 32'd4;
    endcase
    assert (ctrl_i.imm_b_sel inside {idd_pkg::IMM_B_I, idd_pkg::IMM_B_S, idd_pkg::IMM_B_B,
                                     idd_pkg::IMM_B_U, idd_pkg::IMM_B_J,
                                     idd_pkg::IMM_B_INCR_PC})
      else $error("immediate select out of range");
  end

  always_comb begin : op_a_mux
    case (ctrl_i.op_a_sel)
      idd_pkg::OP_A_REG_A:  operand_a_o = rdata_a_i;
      idd_pkg::OP_A_CURRPC: operand_a_o = pc_i;
      default:              operand_a_o = '0;
    endcase
  end

  assign operand_b_o = (ctrl_i.op_b_sel == idd_pkg::OP_B_IMM) ? imm_b : rdata_b_i;

endmodule

// File: design/register_file.sv
// Flip-flop register file, two combinational read ports, one write port.
// x0 has no storage; it reads zero and writes to it are dropped.

`timescale 1ns/1ps

module register_file (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [idd_pkg::REG_ADDR_W-1:0]  raddr_a_i,
  input  logic [idd_pkg::REG_ADDR_W-1:0]  raddr_b_i,
  input  logic [idd_pkg::REG_ADDR_W-1:0]  waddr_i,
  input  logic [idd_pkg::XLEN-1:0]        wdata_i,
  input  logic                            we_i,
  output logic [idd_pkg::XLEN-1:0]        rdata_a_o,
  output logic [idd_pkg::XLEN-1:0]        rdata_b_o
);

  // Storage for x1 .. x31
  logic [idd_pkg::XLEN-1:0] rf_q [1:idd_pkg::NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rf_q <= '{default: '0};
    end else if (we_i && waddr_i != '0) begin
      rf_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : rf_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : rf_q[raddr_b_i];

endmodule

// File: tb/id_stage_tb.sv
// Self-checking testbench for the RV32I decode stage.
// The testbench plays EX and LSU and keeps its own register model.
// Inputs change on falling edges and outputs are checked a quarter period later.

`timescale 1ns/1ps

module id_stage_tb;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned MAX_CYCLES = 4000;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  instr_new_i;
  idd_pkg::instr_t       instr_i;
  logic [31:0]           pc_i;
  logic                  branch_decision_i;
  logic                  ex_valid_i;
  logic [31:0]           ex_wdata_i;
  logic                  lsu_valid_i;
  logic [31:0]           lsu_rdata_i;
  idd_pkg::ex_req_t      ex_req_o;
  idd_pkg::lsu_req_t     lsu_req_o;
  logic                  branch_set_o;
  logic                  id_ready_o;
  logic                  instr_ret_o;
  logic                  illegal_insn_o;

  logic [31:0] model [32];
  int          seed;
  int          errors;
  int          tests;
  int          err_base;
  int          cycles = 0;

  id_stage UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Encoders and checks
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rd,
                                        logic [6:0] op);
    return {imm, rs1, 3'b000, rd, op};
  endfunction

  function automatic logic [31:0] enc_add(logic [4:0] rs2, logic [4:0] rs1, logic [4:0] rd);
    return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] rnd;
    rnd = $random(seed);
    return (rnd[4:0] == 5'd0) ? 5'd1 : rnd[4:0];
  endfunction

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    assert (act === exp)
      else begin
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        errors++;
      end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    assert (act === exp)
      else begin
        $display("Fail %s: expected %b, actual %b", name, exp, act);
        errors++;
      end
  endtask

  task automatic end_test(string name);
    tests++;
    if (errors == err_base) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - err_base);
    err_base = errors;
  endtask

  task automatic strobe(logic [31:0] word, logic [31:0] pc, logic [31:0] wdata);
    @(negedge clk_i);
    instr_new_i = 1'b1;
    instr_i     = word;
    pc_i        = pc;
    ex_wdata_i  = wdata;
    #(CLK_PERIOD / 4);
  endtask

  task automatic next_cycle();
    @(negedge clk_i);
    instr_new_i       = 1'b0;
    branch_decision_i = 1'b0;
    ex_valid_i        = 1'b0;
    lsu_valid_i       = 1'b0;
    #(CLK_PERIOD / 4);
  endtask

  // Single-cycle ADD-type instruction, EX result is a + b
  task automatic alu_instr(string name, logic [31:0] word, logic [31:0] pc,
                           logic [31:0] exp_a, logic [31:0] exp_b);
    strobe(word, pc, exp_a + exp_b);
    check_val({name, " operand_a"}, exp_a, ex_req_o.operand_a);
    check_val({name, " operand_b"}, exp_b, ex_req_o.operand_b);
    check_val({name, " alu_op"}, idd_pkg::ALU_ADD, ex_req_o.alu_op);
    check_bit({name, " retire"}, 1'b1, instr_ret_o);
    check_bit({name, " ready"}, 1'b1, id_ready_o);
    check_bit({name, " legal"}, 1'b0, illegal_insn_o);
    if (word[11:7] != 5'd0) model[word[11:7]] = exp_a + exp_b;
    next_cycle();
  endtask

  task automatic read_reg(string name, logic [4:0] r);
    alu_instr(name, enc_add(5'd0, r, 5'd0), 32'h0, model[r], 32'h0);
  endtask

  // Wait cycles, then the completion strobe from LSU or EX
  task automatic complete(string name, int delay, logic from_lsu);
    for (int i = 0; i < delay; i++) begin
      check_bit({name, " ready low"}, 1'b0, id_ready_o);
      check_bit({name, " no retire"}, 1'b0, instr_ret_o);
      check_bit({name, " lsu req"}, from_lsu, lsu_req_o.req);
      next_cycle();
    end
    @(negedge clk_i);
    if (from_lsu) begin
      lsu_valid_i = 1'b1;
      lsu_rdata_i = $random(seed);
    end else begin
      ex_valid_i = 1'b1;
    end
    #(CLK_PERIOD / 4);
    check_bit({name, " retire"}, 1'b1, instr_ret_o);
    next_cycle();
    while (!id_ready_o) next_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    logic [31:0] word;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    int          delay;

    seed = 32'h7f63aa5e;
    errors = 0;
    tests = 0;
    err_base = 0;
    rst_ni = 1'b0;
    instr_new_i = 1'b0;
    instr_i = '0;
    pc_i = '0;
    branch_decision_i = 1'b0;
    ex_valid_i = 1'b0;
    ex_wdata_i = '0;
    lsu_valid_i = 1'b0;
    lsu_rdata_i = '0;
    for (int i = 0; i < 32; i++) model[i] = '0;

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #(CLK_PERIOD / 4);
    check_bit("reset branch_set", 1'b0, branch_set_o);
    check_bit("reset retire", 1'b0, instr_ret_o);
    check_bit("reset lsu req", 1'b0, lsu_req_o.req);
    check_bit("reset ready", 1'b1, id_ready_o);
    end_test("reset");

    // ADDI loads, ADD reads two registers, writes to x0 are dropped
    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      rs1 = rand_reg();
      rd = rand_reg();
      alu_instr("addi", enc_i(rnd[11:0], rs1, rd, 7'h13), 32'h0, model[rs1], sext12(rnd[11:0]));
    end
    for (int i = 0; i < 10; i++) begin
      rs1 = rand_reg();
      rs2 = rand_reg();
      alu_instr("add", enc_add(rs2, rs1, rand_reg()), 32'h0, model[rs1], model[rs2]);
    end
    alu_instr("addi x0", enc_i(12'h7ff, 5'd1, 5'd0, 7'h13), 32'h0, model[1], 32'h7ff);
    read_reg("x0 read", 5'd0);
    end_test("addi/add write-back");

    // LUI, AUIPC and store immediates
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      rd = rand_reg();
      alu_instr("lui", {rnd[31:12], rd, 7'h37}, 32'h0, 32'h0, {rnd[31:12], 12'h000});
      rnd = $random(seed);
      alu_instr("auipc", {rnd[31:12], rd, 7'h17}, 32'h100, 32'h100, {rnd[31:12], 12'h000});
      rnd = $random(seed);
      rs1 = rand_reg();
      rs2 = rand_reg();
      word = {rnd[11:5], rs2, rs1, 3'b010, rnd[4:0], 7'h23};
      // EX data differs from the register that a stray write would hit
      strobe(word, 32'h0, ~model[rnd[4:0]]);
      check_val("store imm", sext12(rnd[11:0]), ex_req_o.operand_b);
      check_val("store wdata", model[rs2], lsu_req_o.wdata);
      check_bit("store we", 1'b1, lsu_req_o.we);
      check_val("store type", idd_pkg::MEM_WORD, lsu_req_o.mem_type);
      next_cycle();
      complete("store", 1, 1'b1);
      read_reg("store rs1 kept", rs1);
      read_reg("store rs2 kept", rs2);
      read_reg("store no write", rnd[4:0]);
    end
    end_test("immediate formats");

    // Loads with random completion delay
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      rs1 = rand_reg();
      rd = rand_reg();
      delay = rnd[14:12];
      strobe(enc_i(rnd[11:0], rs1, rd, 7'h03) | 32'h2000, 32'h0, 32'h0);
      check_val("load base", model[rs1], ex_req_o.operand_a);
      check_val("load offset", sext12(rnd[11:0]), ex_req_o.operand_b);
      check_bit("load req", 1'b1, lsu_req_o.req);
      check_bit("load we", 1'b0, lsu_req_o.we);
      check_val("load type", idd_pkg::MEM_WORD, lsu_req_o.mem_type);
      check_bit("load sign_ext", 1'b1, lsu_req_o.sign_ext);
      check_bit("load no retire", 1'b0, instr_ret_o);
      next_cycle();
      complete("load", delay + 1, 1'b1);
      model[rd] = lsu_rdata_i;
      read_reg("load rd", rd);
    end
    end_test("load sequence");

    // Not-taken then taken branch
    strobe({7'h0, 5'd2, 5'd1, 3'b000, 5'b01000, 7'h63}, 32'h200, 32'h0);
    check_val("beq alu_op", idd_pkg::ALU_EQ, ex_req_o.alu_op);
    check_bit("beq retire", 1'b1, instr_ret_o);
    check_bit("beq ready", 1'b1, id_ready_o);
    next_cycle();
    check_bit("beq no branch_set", 1'b0, branch_set_o);
    @(negedge clk_i);
    instr_new_i       = 1'b1;
    instr_i           = {7'h0, 5'd2, 5'd1, 3'b001, 5'b01000, 7'h63};
    pc_i              = 32'h204;
    branch_decision_i = 1'b1;
    #(CLK_PERIOD / 4);
    check_val("bne alu_op", idd_pkg::ALU_NE, ex_req_o.alu_op);
    check_bit("taken no retire", 1'b0, instr_ret_o);
    next_cycle();
    check_bit("branch_set pulse", 1'b1, branch_set_o);
    check_bit("taken ready", 1'b0, id_ready_o);
    next_cycle();
    check_bit("branch_set single", 1'b0, branch_set_o);
    complete("taken branch", 2, 1'b0);
    end_test("branches");

    // JAL link value
    rd = rand_reg();
    strobe({20'h0, rd, 7'h6f}, 32'h300, 32'h304);
    check_val("jal operand_a", 32'h300, ex_req_o.operand_a);
    check_val("jal operand_b", 32'h4, ex_req_o.operand_b);
    check_val("jal alu_op", idd_pkg::ALU_ADD, ex_req_o.alu_op);
    check_bit("jal no retire", 1'b0, instr_ret_o);
    next_cycle();
    complete("jal", 3, 1'b0);
    model[rd] = 32'h304;
    read_reg("jal rd", rd);
    end_test("jal link");

    // Reserved opcode
    rd = rand_reg();
    strobe({20'h0, rd, 7'h0b}, 32'h400, 32'hdead_beef);
    check_bit("illegal flag", 1'b1, illegal_insn_o);
    check_bit("illegal retire", 1'b0, instr_ret_o);
    next_cycle();
    read_reg("illegal rd", rd);
    end_test("illegal opcode");

    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
design/idd_pkg.sv
design/instr_decoder.sv
design/operand_mux.sv
design/register_file.sv
design/multicycle_fsm.sv
design/id_stage.sv
tb/id_stage_tb.sv
